// File: source/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// processing lanes
// also the element count of one memory word
`define CONV_PE_SIZE 4

// signed operand width
`define CONV_ELEM_W 8

// lane accumulator width
// holds PE_SIZE int8 products with headroom
`define CONV_ACC_W 20

// activation memory
`define CONV_ACT_DEPTH 16
`define CONV_ACT_AW 4

// weight memory holds one row per lane
`define CONV_WGT_DEPTH `CONV_PE_SIZE
`define CONV_WGT_AW 2

// result buffer entries
// power of two keeps the pointer wrap simple
`define CONV_RES_FIFO_DEPTH 4

`endif

// File: source/conv_data_pkg.sv
`include "conv_config.svh"

package conv_data_pkg;

        // one signed element
        typedef logic signed [`CONV_ELEM_W-1:0] elem_t;

        // one memory word
        // weight row or activation vector, same layout
        typedef elem_t [`CONV_PE_SIZE-1:0] elem_vec_t;

        // dot product of one lane
        typedef logic signed [`CONV_ACC_W-1:0] lane_sum_t;

        // all lane sums of one activation
        typedef lane_sum_t [`CONV_PE_SIZE-1:0] sum_vec_t;

        // one outgoing result word
        typedef struct packed {
                // set on the final activation of a pass
                logic     last;
                // index k is lane k
                sum_vec_t sums;
        } res_word_t;

endpackage

// File: source/conv_ctrl_pkg.sv
`include "conv_config.svh"

package conv_ctrl_pkg;

        // request to one tile memory
        // address sized for the activation memory, weights use the low bits
        typedef struct packed {
                logic                    ce;
                logic [`CONV_ACT_AW-1:0] addr;
        } mem_req_t;

        // target of a load request
        typedef enum logic {
                MEM_SEL_WGT = 1'b0,
                MEM_SEL_ACT = 1'b1
        } mem_sel_e;

        // external load port, only honoured while idle
        typedef struct packed {
                logic                      valid;
                mem_sel_e                  sel;
                logic [`CONV_ACT_AW-1:0]   addr;
                conv_data_pkg::elem_vec_t  data;
        } load_req_t;

        // mover sequence
        typedef enum logic [1:0] {
                MV_IDLE  = 2'd0,
                MV_WGT   = 2'd1,
                MV_ACT   = 2'd2,
                MV_DRAIN = 2'd3
        } mover_state_e;

endpackage

// File: source/tile_sram.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module tile_sram #(
        parameter int DEPTH = `CONV_ACT_DEPTH,
        parameter int AW    = `CONV_ACT_AW
) (
        input  logic                     clk,
        input  logic                     rst_n,
        input  conv_ctrl_pkg::mem_req_t  req_i,
        input  logic                     we_i,
        input  conv_data_pkg::elem_vec_t wdata_i,
        output conv_data_pkg::elem_vec_t rdata_o
);

        conv_data_pkg::elem_vec_t mem_q [DEPTH];

        // write port
        always_ff @(posedge clk) begin
                if (req_i.ce && we_i) begin
                        mem_q[req_i.addr[AW-1:0]] <= wdata_i;
                end
        end

        // registered read, data one cycle after ce
        // output holds between reads
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        rdata_o <= '0;
                end else if (req_i.ce && !we_i) begin
                        rdata_o <= mem_q[req_i.addr[AW-1:0]];
                end
        end

endmodule

// File: source/conv_data_mover.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_data_mover (
        input  logic                      clk,
        input  logic                      rst_n,
        input  logic                      start_i,
        input  logic [`CONV_ACT_AW:0]     act_count_i,
        input  conv_data_pkg::elem_vec_t  wgt_q_i,
        input  conv_data_pkg::elem_vec_t  act_q_i,
        input  logic                      credit_i,
        input  logic                      drain_done_i,
        output conv_ctrl_pkg::mem_req_t   wgt_req_o,
        output conv_ctrl_pkg::mem_req_t   act_req_o,
        output logic [`CONV_PE_SIZE-1:0]  wgt_load_o,
        output conv_data_pkg::elem_vec_t  wgt_data_o,
        output logic                      act_valid_o,
        output conv_data_pkg::elem_vec_t  act_data_o,
        output logic                      act_last_o,
        output logic                      busy_o
);

        localparam int WGT_LAST = `CONV_PE_SIZE - 1;

        conv_ctrl_pkg::mover_state_e state_q;
        conv_ctrl_pkg::mover_state_e state_d;

        logic [`CONV_WGT_AW-1:0]  wgt_cnt_q;
        logic [`CONV_ACT_AW-1:0]  act_addr_q;
        logic [`CONV_ACT_AW-1:0]  act_end_q;
        logic                     wgt_rd;
        logic                     act_rd;
        logic                     act_rd_end;
        logic [`CONV_PE_SIZE-1:0] wgt_onehot;

        // read enables
        assign wgt_rd     = (state_q == conv_ctrl_pkg::MV_WGT);
        // activation read only with a credit
        assign act_rd     = (state_q == conv_ctrl_pkg::MV_ACT) && credit_i;
        assign act_rd_end = act_rd && (act_addr_q == act_end_q);

        always_comb begin
                state_d = state_q;
                case (state_q)
                        conv_ctrl_pkg::MV_IDLE: begin
                                // start ignored anywhere else
                                if (start_i) begin
                                        state_d = conv_ctrl_pkg::MV_WGT;
                                end
                        end
                        conv_ctrl_pkg::MV_WGT: begin
                                // one row per cycle, PE_SIZE rows
                                if (wgt_cnt_q == WGT_LAST[`CONV_WGT_AW-1:0]) begin
                                        state_d = conv_ctrl_pkg::MV_ACT;
                                end
                        end
                        conv_ctrl_pkg::MV_ACT: begin
                                if (act_rd_end) begin
                                        state_d = conv_ctrl_pkg::MV_DRAIN;
                                end
                        end
                        conv_ctrl_pkg::MV_DRAIN: begin
                                // wait for the last word to leave
                                if (drain_done_i) begin
                                        state_d = conv_ctrl_pkg::MV_IDLE;
                                end
                        end
                        default: state_d = conv_ctrl_pkg::MV_IDLE;
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state_q    <= conv_ctrl_pkg::MV_IDLE;
                        wgt_cnt_q  <= '0;
                        act_addr_q <= '0;
                        act_end_q  <= '0;
                end else begin
                        state_q <= state_d;
                        if ((state_q == conv_ctrl_pkg::MV_IDLE) && start_i) begin
                                wgt_cnt_q  <= '0;
                                act_addr_q <= '0;
                                // count of 16 wraps to address 15
                                act_end_q  <= act_count_i[`CONV_ACT_AW-1:0] - 1'b1;
                        end
                        if (wgt_rd) begin
                                wgt_cnt_q <= wgt_cnt_q + 1'b1;
                        end
                        // address holds while credit is low
                        if (act_rd && !act_rd_end) begin
                                act_addr_q <= act_addr_q + 1'b1;
                        end
                end
        end

        // lane select of the current weight read
        always_comb begin
                wgt_onehot            = '0;
                wgt_onehot[wgt_cnt_q] = wgt_rd;
        end

        // strobes follow the read by one cycle
        // lines up with the sram output
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wgt_load_o  <= '0;
                        act_valid_o <= 1'b0;
                        act_last_o  <= 1'b0;
                end else begin
                        wgt_load_o  <= wgt_onehot;
                        act_valid_o <= act_rd;
                        act_last_o  <= act_rd_end;
                end
        end

        always_comb begin
                wgt_req_o.ce                     = wgt_rd;
                wgt_req_o.addr                   = '0;
                wgt_req_o.addr[`CONV_WGT_AW-1:0] = wgt_cnt_q;
                act_req_o.ce                     = act_rd;
                act_req_o.addr                   = act_addr_q;
        end

        // weight row goes to every lane, strobe picks one
        assign wgt_data_o = wgt_q_i;
        // activation broadcast
        assign act_data_o = act_q_i;
        assign busy_o     = (state_q != conv_ctrl_pkg::MV_IDLE);

endmodule

// File: source/pe_lane.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module pe_lane (
        input  logic                      clk,
        input  logic                      rst_n,
        input  logic                      wgt_load_i,
        input  conv_data_pkg::elem_vec_t  wgt_i,
        input  logic                      act_valid_i,
        input  conv_data_pkg::elem_vec_t  act_i,
        input  logic                      act_last_i,
        output conv_data_pkg::lane_sum_t  sum_o,
        output logic                      sum_valid_o,
        output logic                      sum_last_o
);

        conv_data_pkg::elem_vec_t wgt_q;
        conv_data_pkg::lane_sum_t dot;

        // stationary row, kept until the next load
        always_ff @(posedge clk) begin
                if (wgt_load_i) begin
                        wgt_q <= wgt_i;
                end
        end

        // sign extend each element before the multiply
        always_comb begin
                dot = '0;
                for (int k = 0; k < `CONV_PE_SIZE; k++) begin
                        dot = dot + conv_data_pkg::lane_sum_t'(wgt_q[k]) *
                                    conv_data_pkg::lane_sum_t'(act_i[k]);
                end
        end

        // sum one cycle after the activation
        always_ff @(posedge clk) begin
                if (act_valid_i) begin
                        sum_o <= dot;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        sum_valid_o <= 1'b0;
                        sum_last_o  <= 1'b0;
                end else begin
                        sum_valid_o <= act_valid_i;
                        sum_last_o  <= act_valid_i && act_last_i;
                end
        end

endmodule

// File: source/result_collector.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module result_collector (
        input  logic                      clk,
        input  logic                      rst_n,
        input  conv_data_pkg::sum_vec_t   sums_i,
        input  logic                      sum_valid_i,
        input  logic                      sum_last_i,
        input  logic                      issue_i,
        input  logic                      res_ready_i,
        output logic                      credit_o,
        output conv_data_pkg::res_word_t  res_o,
        output logic                      res_valid_o,
        output logic                      drain_done_o
);

        localparam int DEPTH = `CONV_RES_FIFO_DEPTH;
        localparam int PW    = $clog2(DEPTH);
        localparam int CW    = $clog2(DEPTH + 1);
        localparam logic [PW-1:0] LAST_SLOT = PW'(DEPTH - 1);

        conv_data_pkg::res_word_t fifo_q [DEPTH];

        logic [PW-1:0] wr_ptr_q;
        logic [PW-1:0] rd_ptr_q;
        logic [CW-1:0] count_q;
        logic [CW-1:0] inflight_q;
        logic [CW:0]   pending;
        logic          push;
        logic          pop;

        // credit reserves the space so push never meets a full buffer
        assign push = sum_valid_i;
        assign pop  = res_valid_o && res_ready_i;

        always_ff @(posedge clk) begin
                if (push) begin
                        fifo_q[wr_ptr_q].sums <= sums_i;
                        fifo_q[wr_ptr_q].last <= sum_last_i;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr_q   <= '0;
                        rd_ptr_q   <= '0;
                        count_q    <= '0;
                        inflight_q <= '0;
                end else begin
                        if (push) begin
                                wr_ptr_q <= (wr_ptr_q == LAST_SLOT) ? '0 : wr_ptr_q + 1'b1;
                        end
                        if (pop) begin
                                rd_ptr_q <= (rd_ptr_q == LAST_SLOT) ? '0 : rd_ptr_q + 1'b1;
                        end
                        // occupancy
                        case ({push, pop})
                                2'b10:   count_q <= count_q + 1'b1;
                                2'b01:   count_q <= count_q - 1'b1;
                                default: count_q <= count_q;
                        endcase
                        // reads issued but not yet summed
                        // each one stays two cycles
                        case ({issue_i, push})
                                2'b10:   inflight_q <= inflight_q + 1'b1;
                                2'b01:   inflight_q <= inflight_q - 1'b1;
                                default: inflight_q <= inflight_q;
                        endcase
                end
        end

        // slots already claimed by stored and in flight words
        assign pending  = {1'b0, count_q} + {1'b0, inflight_q};
        // at least one slot left unclaimed
        assign credit_o = (pending < DEPTH[CW:0]);

        // head word stays put until taken
        assign res_o        = fifo_q[rd_ptr_q];
        assign res_valid_o  = (count_q != '0);
        // end of pass seen at the output
        assign drain_done_o = pop && res_o.last;

endmodule

// File: source/conv_tile_top.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_tile_top (
        input  logic                      clk,
        input  logic                      rst_n,
        input  conv_ctrl_pkg::load_req_t  load_i,
        input  logic                      start_i,
        input  logic [`CONV_ACT_AW:0]     act_count_i,
        input  logic                      res_ready_i,
        output conv_data_pkg::res_word_t  res_o,
        output logic                      res_valid_o,
        output logic                      busy_o
);

        conv_ctrl_pkg::mem_req_t   mv_wgt_req;
        conv_ctrl_pkg::mem_req_t   mv_act_req;
        conv_ctrl_pkg::mem_req_t   wgt_port;
        conv_ctrl_pkg::mem_req_t   act_port;
        logic                      wgt_we;
        logic                      act_we;
        conv_data_pkg::elem_vec_t  wgt_q;
        conv_data_pkg::elem_vec_t  act_q;
        conv_data_pkg::elem_vec_t  wgt_data;
        conv_data_pkg::elem_vec_t  act_data;
        logic [`CONV_PE_SIZE-1:0]  wgt_load;
        logic                      act_valid;
        logic                      act_last;
        logic                      credit;
        logic                      drain_done;
        conv_data_pkg::sum_vec_t   lane_sums;
        logic [`CONV_PE_SIZE-1:0]  lane_valid;
        logic [`CONV_PE_SIZE-1:0]  lane_last;

        // load port owns both memories while the mover is idle
        always_comb begin
                wgt_we = !busy_o && load_i.valid && (load_i.sel == conv_ctrl_pkg::MEM_SEL_WGT);
                act_we = !busy_o && load_i.valid && (load_i.sel == conv_ctrl_pkg::MEM_SEL_ACT);
                if (busy_o) begin
                        wgt_port = mv_wgt_req;
                        act_port = mv_act_req;
                end else begin
                        wgt_port.ce   = wgt_we;
                        wgt_port.addr = load_i.addr;
                        act_port.ce   = act_we;
                        act_port.addr = load_i.addr;
                end
        end

        tile_sram #(.DEPTH(`CONV_WGT_DEPTH), .AW(`CONV_WGT_AW)) wgt_sram_i (
                .clk(clk), .rst_n(rst_n), .req_i(wgt_port), .we_i(wgt_we),
                .wdata_i(load_i.data), .rdata_o(wgt_q)
        );

        tile_sram #(.DEPTH(`CONV_ACT_DEPTH), .AW(`CONV_ACT_AW)) act_sram_i (
                .clk(clk), .rst_n(rst_n), .req_i(act_port), .we_i(act_we),
                .wdata_i(load_i.data), .rdata_o(act_q)
        );

        conv_data_mover conv_data_mover_i (
                .clk(clk), .rst_n(rst_n), .start_i(start_i), .act_count_i(act_count_i),
                .wgt_q_i(wgt_q), .act_q_i(act_q), .credit_i(credit),
                .drain_done_i(drain_done), .wgt_req_o(mv_wgt_req), .act_req_o(mv_act_req),
                .wgt_load_o(wgt_load), .wgt_data_o(wgt_data), .act_valid_o(act_valid),
                .act_data_o(act_data), .act_last_o(act_last), .busy_o(busy_o)
        );

        // one lane per weight row
        for (genvar k = 0; k < `CONV_PE_SIZE; k++) begin : g_lane
                pe_lane pe_lane_i (
                        .clk(clk), .rst_n(rst_n), .wgt_load_i(wgt_load[k]),
                        .wgt_i(wgt_data), .act_valid_i(act_valid), .act_i(act_data),
                        .act_last_i(act_last), .sum_o(lane_sums[k]),
                        .sum_valid_o(lane_valid[k]), .sum_last_o(lane_last[k])
                );
        end

        // lanes run in lockstep, flags agree across all of them
        result_collector result_collector_i (
                .clk(clk), .rst_n(rst_n), .sums_i(lane_sums),
                .sum_valid_i(&lane_valid), .sum_last_i(&lane_last),
                .issue_i(mv_act_req.ce), .res_ready_i(res_ready_i), .credit_o(credit),
                .res_o(res_o), .res_valid_o(res_valid_o), .drain_done_o(drain_done)
        );

endmodule

// File: dv/conv_tile_tb.sv
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_tile_tb;

        localparam int PE        = `CONV_PE_SIZE;
        localparam int ACT_DEPTH = `CONV_ACT_DEPTH;
        localparam int AW        = `CONV_ACT_AW;
        localparam int NUM_ROWS  = 7;
        localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

        // one test step: activations, ready pattern, weight mode
        // weight mode 0 keeps rows, 1 loads random rows, 2 loads -128 rows
        typedef struct packed {
                logic [AW:0] act_count;
                logic [7:0]  ready_mask;
                logic [1:0]  reload;
        } test_row_t;

        test_row_t rows [NUM_ROWS] = '{
                '{5'd4,  8'hff, 2'd1},
                '{5'd8,  8'h55, 2'd0},
                '{5'd16, 8'hff, 2'd1},
                '{5'd1,  8'hff, 2'd2},
                '{5'd16, 8'h11, 2'd1},
                '{5'd10, 8'h9c, 2'd2},
                '{5'd1,  8'h10, 2'd0}
        };

        logic                     clk;
        logic                     rst_n;
        conv_ctrl_pkg::load_req_t load_i;
        logic                     start_i;
        logic [AW:0]              act_count_i;
        logic                     res_ready_i;
        conv_data_pkg::res_word_t res_o;
        logic                     res_valid_o;
        logic                     busy_o;

        // reference copies of both memories
        conv_data_pkg::elem_vec_t wgt_m [PE];
        conv_data_pkg::elem_vec_t act_m [ACT_DEPTH];
        int                       exp_m [ACT_DEPTH][PE];

        logic [31:0] lfsr_q = 32'hc5e0dcb1;
        int          cycle_cnt = 0;
        int          cycle_limit = 0;

        conv_tile_top conv_tile_top_i (
                .clk(clk), .rst_n(rst_n), .load_i(load_i), .start_i(start_i),
                .act_count_i(act_count_i), .res_ready_i(res_ready_i), .res_o(res_o),
                .res_valid_o(res_valid_o), .busy_o(busy_o)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        // run limit, stops a hung pass
        always @(posedge clk) begin
                cycle_cnt++;
                if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
                        $display("timeout: run did not finish within %0d cycles", cycle_limit);
                        $display("Result: FAILED");
                        $fatal(1, "run stopped on timeout");
                end
        end

        // galois shift, one step per bit
        function automatic logic [31:0] lfsr_bits(input int n);
                logic [31:0] v;
                logic        b;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        b      = lfsr_q[0];
                        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? LFSR_TAPS : 32'h0);
                        v      = {v[30:0], b};
                end
                return v;
        endfunction

        function automatic conv_data_pkg::elem_vec_t rand_vec();
                conv_data_pkg::elem_vec_t v;
                for (int j = 0; j < PE; j++) begin
                        v[j] = 8'(lfsr_bits(8));
                end
                return v;
        endfunction

        // signed matrix row times activation
        function automatic int dot(input conv_data_pkg::elem_vec_t w,
                                   input conv_data_pkg::elem_vec_t a);
                int s;
                s = 0;
                for (int j = 0; j < PE; j++) begin
                        s = s + int'(w[j]) * int'(a[j]);
                end
                return s;
        endfunction

        task automatic compare_value(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
                if (got !== exp) begin
                        $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
                        $display("Result: FAILED");
                        $fatal(1, "value mismatch");
                end
        endtask

        // one write through the load port
        task automatic load_word(input conv_ctrl_pkg::mem_sel_e sel, input int addr,
                                 input conv_data_pkg::elem_vec_t data);
                @(negedge clk);
                load_i.valid = 1'b1;
                load_i.sel   = sel;
                load_i.addr  = AW'(addr);
                load_i.data  = data;
        endtask

        initial begin
                test_row_t                row;
                conv_data_pkg::res_word_t prev_res;
                int                       n;
                int                       got;
                int                       waited;
                logic                     stalled;
                rst_n       = 1'b0;
                load_i      = '0;
                start_i     = 1'b0;
                act_count_i = '0;
                res_ready_i = 1'b0;
                for (int r = 0; r < NUM_ROWS; r++) begin
                        cycle_limit += 4 * (PE + int'(rows[r].act_count) + 8);
                end
                repeat (5) @(posedge clk);
                compare_value("busy_o", 32'(busy_o), 32'd0);
                compare_value("res_valid_o", 32'(res_valid_o), 32'd0);
                @(negedge clk);
                rst_n = 1'b1;
                // idle with no start, nothing may come out
                repeat (4) begin
                        @(negedge clk);
                        compare_value("busy_o", 32'(busy_o), 32'd0);
                        compare_value("res_valid_o", 32'(res_valid_o), 32'd0);
                end
                for (int r = 0; r < NUM_ROWS; r++) begin
                        row = rows[r];
                        n   = int'(row.act_count);
                        // new stationary rows
                        if (row.reload != 2'd0) begin
                                for (int k = 0; k < PE; k++) begin
                                        wgt_m[k] = (row.reload == 2'd2) ? {PE{8'h80}} : rand_vec();
                                        load_word(conv_ctrl_pkg::MEM_SEL_WGT, k, wgt_m[k]);
                                end
                        end
                        // extreme rows mix -128 vectors with random ones
                        for (int i = 0; i < n; i++) begin
                                if (row.reload == 2'd2 && (i % 2) == 0) begin
                                        act_m[i] = {PE{8'h80}};
                                end else begin
                                        act_m[i] = rand_vec();
                                end
                                load_word(conv_ctrl_pkg::MEM_SEL_ACT, i, act_m[i]);
                        end
                        for (int i = 0; i < n; i++) begin
                                for (int k = 0; k < PE; k++) begin
                                        exp_m[i][k] = dot(wgt_m[k], act_m[i]);
                                end
                        end
                        got     = 0;
                        waited  = 0;
                        stalled = 1'b0;
                        while (got < n) begin
                                @(negedge clk);
                                load_i.valid = 1'b0;
                                // real start, then a stray one while busy
                                start_i      = (waited == 0) || (waited == 3);
                                act_count_i  = (waited == 3) ? 5'd2 : row.act_count;
                                res_ready_i  = row.ready_mask[waited[2:0]];
                                if (waited == 0) begin
                                        compare_value("busy_o", 32'(busy_o), 32'd0);
                                end
                                if (waited == 3) begin
                                        compare_value("busy_o", 32'(busy_o), 32'd1);
                                end
                                // stalled word must stay put
                                if (stalled) begin
                                        compare_value("res_valid_o", 32'(res_valid_o), 32'd1);
                                        compare_value("res_o.last", 32'(res_o.last),
                                                      32'(prev_res.last));
                                        for (int k = 0; k < PE; k++) begin
                                                compare_value($sformatf("res_o.sums[%0d]", k),
                                                              int'(res_o.sums[k]),
                                                              int'(prev_res.sums[k]));
                                        end
                                end
                                if (res_valid_o && res_ready_i) begin
                                        for (int k = 0; k < PE; k++) begin
                                                compare_value($sformatf("res_o.sums[%0d]", k),
                                                              int'(res_o.sums[k]), exp_m[got][k]);
                                        end
                                        compare_value("res_o.last", 32'(res_o.last),
                                                      32'(got == n - 1));
                                        got++;
                                end
                                stalled  = res_valid_o && !res_ready_i;
                                prev_res = res_o;
                                waited++;
                        end
                        @(negedge clk);
                        start_i     = 1'b0;
                        res_ready_i = 1'b0;
                        // pass over, no extra word left behind
                        compare_value("busy_o", 32'(busy_o), 32'd0);
                        compare_value("res_valid_o", 32'(res_valid_o), 32'd0);
                end
                $display("Result: PASSED");
                $finish;
        end

endmodule

// File: files.f
+incdir+source
source/conv_data_pkg.sv
source/conv_ctrl_pkg.sv
source/tile_sram.sv
source/conv_data_mover.sv
source/pe_lane.sv
source/result_collector.sv
source/conv_tile_top.sv
dv/conv_tile_tb.sv

// File: Makefile
# Verilator build and run for the convolution tile testbench

VERILATOR ?= verilator
TOP       ?= conv_tile_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= Result: PASSED

SRCS := $(wildcard source/*.sv source/*.svh dv/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
